/* common/dcache_pkg.sv */
/*
 * Shared types and line geometry of the data cache.
 * Word, byte-enable, address and word-index types, controller states.
 */

package dcache_pkg;

        // --------------------------------------------------
        // Geometry.
        // --------------------------------------------------
        localparam int ADDR_W         = 32;  // Byte address.
        localparam int WORD_W         = 32;  // Data word.
        localparam int WORDS_PER_LINE = 4;   // Words in one line.
        localparam int OFFSET_W       = 4;   // Byte offset in a line.

        // --------------------------------------------------
        // Types.
        // --------------------------------------------------
        typedef logic [WORD_W-1:0]                 word_t;     // One word.
        typedef logic [WORD_W/8-1:0]               ben_t;      // Byte enables.
        typedef logic [ADDR_W-1:0]                 addr_t;     // Byte address.
        typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_idx_t; // Word in line.

        // Controller states.
        typedef enum logic [2:0]
        {
                IDLE    = 3'd0,  // Waiting for a request.
                LOOKUP  = 3'd1,  // Tag compare, read hit served.
                FILL    = 3'd2,  // Line fill from RAM.
                REFRESH = 3'd3,  // Store re-read after fill.
                WRITE   = 3'd4,  // Write-through to RAM.
                BYPASS  = 3'd5   // Cache disabled, straight to RAM.
        } ctrl_state_t;

endpackage

/* dcache/fill_counter.sv */
/*
 * Word counter for a line fill.
 */

`timescale 1ns/1ps

module fill_counter (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_start,        // Clear to word 0.
        input  logic                    i_advance,      // Step one word.
        output dcache_pkg::word_idx_t   o_idx,          // Current word.
        output logic                    o_last          // Final word of line.
);

        import dcache_pkg::*;

        word_idx_t idx_ff;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_start)
                        idx_ff <= '0;
                else if (i_advance)
                        idx_ff <= idx_ff + 1'b1;  // Wraps after the last word.
        end

        assign o_idx  = idx_ff;
        assign o_last = (idx_ff == word_idx_t'(WORDS_PER_LINE - 1));

endmodule

/* dcache/tag_store.sv */
/*
 * Tag memory with one valid bit per line.
 * Registered read, global invalidate.
 */

`timescale 1ns/1ps

module tag_store #(
        parameter int CACHE_LINES = 64
) (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  dcache_pkg::addr_t       i_address,      // Read and write index.
        input  logic                    i_wr_en,        // Install tag.
        input  logic                    i_inv,          // Clear all valid bits.
        output logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-$clog2(CACHE_LINES)-1:0] o_tag,
        output logic                    o_valid
);

        import dcache_pkg::*;

        localparam int INDEX_W = $clog2(CACHE_LINES);
        localparam int TAG_W   = ADDR_W - OFFSET_W - INDEX_W;

        logic [TAG_W-1:0]       tags [CACHE_LINES];     // Tag array.
        logic [CACHE_LINES-1:0] valid;                  // Valid bits.
        logic [INDEX_W-1:0]     index;

        assign index = i_address[OFFSET_W +: INDEX_W];

        // Tag array.
        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                        tags[index] <= i_address[ADDR_W-1 -: TAG_W];
                o_tag <= tags[index];
        end

        // --------------------------------------------------
        // Valid bits.
        // --------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_inv)
                begin
                        valid   <= '0;
                        o_valid <= 1'b0;        // Never reads stale after invalidate.
                end
                else
                begin
                        if (i_wr_en)
                                valid[index] <= 1'b1;
                        o_valid <= valid[index];
                end
        end

endmodule

/* dcache/line_store.sv */
/*
 * Line data memory with byte writes into one word.
 * Registered word read, RAM data passed through in bypass.
 */

`timescale 1ns/1ps

module line_store #(
        parameter int CACHE_LINES = 64
) (
        input  logic                    i_clk,
        input  dcache_pkg::addr_t       i_address,      // Line index, read word.
        input  logic                    i_wr_en,        // Word write.
        input  dcache_pkg::word_idx_t   i_wr_idx,       // Word in line to write.
        input  dcache_pkg::ben_t        i_ben,
        input  dcache_pkg::word_t       i_wr_data,
        input  dcache_pkg::word_t       i_ram_rd_data,  // Bypass source.
        input  logic                    i_bypass,
        output dcache_pkg::word_t       o_rd_data
);

        import dcache_pkg::*;

        localparam int INDEX_W  = $clog2(CACHE_LINES);
        localparam int WORD_LSB = OFFSET_W - $clog2(WORDS_PER_LINE);
        localparam int MEM_AW   = INDEX_W + $bits(word_idx_t);

        word_t                  mem [CACHE_LINES * WORDS_PER_LINE];
        word_t                  rd_q;           // Registered word.
        logic [INDEX_W-1:0]     index;
        logic [MEM_AW-1:0]      wr_addr;
        logic [MEM_AW-1:0]      rd_addr;

        assign index   = i_address[OFFSET_W +: INDEX_W];
        assign wr_addr = {index, i_wr_idx};
        assign rd_addr = {index, i_address[OFFSET_W-1:WORD_LSB]};

        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                begin
                        for (int b = 0; b < WORD_W/8; b++)
                        begin
                                if (i_ben[b])
                                        mem[wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
                        end
                end
                rd_q <= mem[rd_addr];   // Old data on a same-cycle write.
        end

        assign o_rd_data = i_bypass ? i_ram_rd_data : rd_q;

endmodule

/* dcache/dcache_ctrl.sv */
/*
 * Cache controller FSM.
 * Tag compare, line fill sequencing, write-through and bypass commands.
 */

`timescale 1ns/1ps

module dcache_ctrl #(
        parameter int CACHE_LINES = 64
) (
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Core side.
        input  logic                    i_read_en,
        input  logic                    i_write_en,
        input  dcache_pkg::ben_t        i_ben,
        input  dcache_pkg::word_t       i_wr_data,
        input  dcache_pkg::addr_t       i_address,
        input  logic                    i_cache_en,
        input  logic                    i_cache_inv,
        output logic                    o_stall,        // Not registered.

        // RAM side. Held until done.
        output logic                    o_ram_rd_en,
        output logic                    o_ram_wr_en,
        output dcache_pkg::addr_t       o_ram_address,
        output dcache_pkg::word_t       o_ram_wr_data,
        output dcache_pkg::ben_t        o_ram_ben,
        input  dcache_pkg::word_t       i_ram_rd_data,
        input  logic                    i_ram_done,

        // Fill counter.
        output logic                    o_fill_start,
        output logic                    o_fill_advance,
        input  dcache_pkg::word_idx_t   i_fill_idx,
        input  logic                    i_fill_last,

        // Tag store.
        input  logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-$clog2(CACHE_LINES)-1:0] i_tag_rd,
        input  logic                    i_tag_valid,
        output logic                    o_tag_wr_en,

        // Line store.
        output logic                    o_line_wr_en,
        output dcache_pkg::ben_t        o_line_ben,
        output dcache_pkg::word_idx_t   o_line_wr_idx,
        output dcache_pkg::word_t       o_line_wr_data,
        output logic                    o_bypass
);

        import dcache_pkg::*;

        localparam int INDEX_W  = $clog2(CACHE_LINES);
        localparam int TAG_W    = ADDR_W - OFFSET_W - INDEX_W;
        localparam int WORD_LSB = OFFSET_W - $clog2(WORDS_PER_LINE); // Byte bits.

        ctrl_state_t    state_ff, state_nxt;
        logic           req;            // Any core request.
        logic           hit;            // Tag match on valid line.
        word_idx_t      word_sel;       // Word of i_address in its line.

        assign req      = i_read_en | i_write_en;
        assign word_sel = i_address[OFFSET_W-1:WORD_LSB];
        // Store outputs track i_address, so this holds in LOOKUP and WRITE.
        assign hit      = i_tag_valid && (i_tag_rd == i_address[ADDR_W-1 -: TAG_W]);
        assign o_bypass = (state_ff == BYPASS);

        // --------------------------------------------------
        // Next state and outputs.
        // --------------------------------------------------
        always_comb
        begin
                state_nxt      = state_ff;
                o_stall        = 1'b0;
                o_ram_rd_en    = 1'b0;
                o_ram_wr_en    = 1'b0;
                o_ram_address  = i_address;     // Request copied by default.
                o_ram_wr_data  = i_wr_data;
                o_ram_ben      = i_ben;
                o_fill_start   = 1'b0;
                o_fill_advance = 1'b0;
                o_tag_wr_en    = 1'b0;
                o_line_wr_en   = 1'b0;
                o_line_ben     = i_ben;
                o_line_wr_idx  = word_sel;
                o_line_wr_data = i_wr_data;

                case (state_ff)
                IDLE:
                begin
                        // Stores sample i_address in this cycle.
                        if (req)
                        begin
                                o_stall = 1'b1;
                                // Invalidate cycle goes first.
                                if (!i_cache_inv)
                                        state_nxt = i_cache_en ? LOOKUP : BYPASS;
                        end
                end

                LOOKUP:
                begin
                        if (i_write_en)
                        begin
                                o_stall   = 1'b1;
                                state_nxt = WRITE;
                        end
                        else if (hit)
                        begin
                                state_nxt = IDLE;       // Read hit done.
                        end
                        else
                        begin
                                o_stall      = 1'b1;
                                o_fill_start = 1'b1;    // Counter back to word 0.
                                state_nxt    = FILL;
                        end
                end

                FILL:
                begin
                        o_stall       = 1'b1;
                        o_ram_rd_en   = 1'b1;
                        o_ram_address = {i_address[ADDR_W-1:OFFSET_W], i_fill_idx,
                                         {WORD_LSB{1'b0}}};
                        o_ram_ben     = '1;

                        // Word arrives straight into the line store.
                        if (i_ram_done)
                        begin
                                o_line_wr_en   = 1'b1;
                                o_line_ben     = '1;
                                o_line_wr_idx  = i_fill_idx;
                                o_line_wr_data = i_ram_rd_data;
                                o_fill_advance = 1'b1;
                                if (i_fill_last)
                                begin
                                        o_tag_wr_en = 1'b1;
                                        state_nxt   = REFRESH;
                                end
                        end
                end

                REFRESH:
                begin
                        // Lets the stores re-read the new line.
                        o_stall   = 1'b1;
                        state_nxt = LOOKUP;
                end

                WRITE:
                begin
                        o_ram_wr_en = 1'b1;
                        o_stall     = !i_ram_done;
                        if (i_ram_done)
                        begin
                                o_line_wr_en = hit;     // No write allocate.
                                state_nxt    = IDLE;
                        end
                end

                BYPASS:
                begin
                        o_ram_rd_en = i_read_en;
                        o_ram_wr_en = i_write_en;
                        o_stall     = !i_ram_done;
                        if (i_ram_done)
                                state_nxt = IDLE;
                end

                default:
                begin
                        state_nxt = IDLE;
                end
                endcase
        end

        // --------------------------------------------------
        // State register.
        // --------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_ff <= IDLE;
                else
                        state_ff <= state_nxt;
        end

endmodule

/* dcache/dcache_top.sv */
/*
 * Top level of the write-through data cache.
 * Wires the controller, fill counter, tag store and line store.
 */

`timescale 1ns/1ps

module dcache_top #(
        parameter int CACHE_LINES = 64              // Power of two.
) (
        input  logic                    i_clk,         // Clock.
        input  logic                    i_reset,       // Sync reset.

        // Core side.
        input  logic                    i_read_en,     // Read request.
        input  logic                    i_write_en,    // Write request.
        input  dcache_pkg::ben_t        i_ben,         // Byte enables.
        input  dcache_pkg::word_t       i_wr_data,     // Write data.
        input  dcache_pkg::addr_t       i_address,     // Byte address.
        input  logic                    i_cache_en,    // Cache enable.
        input  logic                    i_cache_inv,   // Invalidate all.
        output dcache_pkg::word_t       o_rd_data,     // Read data.
        output logic                    o_stall,       // Hold request.

        // RAM side.
        output logic                    o_ram_rd_en,   // RAM read.
        output logic                    o_ram_wr_en,   // RAM write.
        output dcache_pkg::addr_t       o_ram_address, // RAM address.
        output dcache_pkg::word_t       o_ram_wr_data, // RAM write data.
        output dcache_pkg::ben_t        o_ram_ben,     // RAM byte enables.
        input  dcache_pkg::word_t       i_ram_rd_data, // RAM read data.
        input  logic                    i_ram_done     // Command complete.
);

        import dcache_pkg::*;

        localparam int TAG_W = ADDR_W - OFFSET_W - $clog2(CACHE_LINES);

        // --------------------------------------------------
        // Internal nets.
        // --------------------------------------------------
        logic                   fill_start;     // Clear fill counter.
        logic                   fill_advance;   // Next fill word.
        word_idx_t              fill_idx;       // Current fill word.
        logic                   fill_last;      // Last word of line.
        logic [TAG_W-1:0]       tag_rd;         // Stored tag.
        logic                   tag_valid;      // Stored valid bit.
        logic                   tag_wr_en;      // Install tag.
        logic                   line_wr_en;     // Line word write.
        ben_t                   line_ben;
        word_idx_t              line_wr_idx;
        word_t                  line_wr_data;
        logic                   bypass;         // Read data from RAM.

        dcache_ctrl #(.CACHE_LINES(CACHE_LINES)) dcache_ctrl_inst (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_read_en      (i_read_en),
                .i_write_en     (i_write_en),
                .i_ben          (i_ben),
                .i_wr_data      (i_wr_data),
                .i_address      (i_address),
                .i_cache_en     (i_cache_en),
                .i_cache_inv    (i_cache_inv),
                .o_stall        (o_stall),
                .o_ram_rd_en    (o_ram_rd_en),
                .o_ram_wr_en    (o_ram_wr_en),
                .o_ram_address  (o_ram_address),
                .o_ram_wr_data  (o_ram_wr_data),
                .o_ram_ben      (o_ram_ben),
                .i_ram_rd_data  (i_ram_rd_data),
                .i_ram_done     (i_ram_done),
                .o_fill_start   (fill_start),
                .o_fill_advance (fill_advance),
                .i_fill_idx     (fill_idx),
                .i_fill_last    (fill_last),
                .i_tag_rd       (tag_rd),
                .i_tag_valid    (tag_valid),
                .o_tag_wr_en    (tag_wr_en),
                .o_line_wr_en   (line_wr_en),
                .o_line_ben     (line_ben),
                .o_line_wr_idx  (line_wr_idx),
                .o_line_wr_data (line_wr_data),
                .o_bypass       (bypass)
        );

        fill_counter fill_counter_inst (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_start        (fill_start),
                .i_advance      (fill_advance),
                .o_idx          (fill_idx),
                .o_last         (fill_last)
        );

        tag_store #(.CACHE_LINES(CACHE_LINES)) tag_store_inst (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_address      (i_address),
                .i_wr_en        (tag_wr_en),
                .i_inv          (i_cache_inv),
                .o_tag          (tag_rd),
                .o_valid        (tag_valid)
        );

        line_store #(.CACHE_LINES(CACHE_LINES)) line_store_inst (
                .i_clk          (i_clk),
                .i_address      (i_address),
                .i_wr_en        (line_wr_en),
                .i_wr_idx       (line_wr_idx),
                .i_ben          (line_ben),
                .i_wr_data      (line_wr_data),
                .i_ram_rd_data  (i_ram_rd_data),
                .i_bypass       (bypass),
                .o_rd_data      (o_rd_data)
        );

endmodule

/* tests/dcache_tb.sv */
/*
 * Testbench for the write-through data cache.
 * Clock, reset, RAM model with random latency, directed tests, compare tasks.
 */

`timescale 1ns/1ps

module dcache_tb;

        import dcache_pkg::*;

        localparam int CACHE_LINES = 64;
        localparam int RAM_WORDS   = 4096;      // 16 KB of model RAM.
        localparam int MAX_CYCLES  = 2000;      // Well above the worst case of all tests.

        logic           i_clk;
        logic           i_reset;
        logic           i_read_en;
        logic           i_write_en;
        ben_t           i_ben;
        word_t          i_wr_data;
        addr_t          i_address;
        logic           i_cache_en;
        logic           i_cache_inv;
        word_t          o_rd_data;
        logic           o_stall;
        logic           o_ram_rd_en;
        logic           o_ram_wr_en;
        addr_t          o_ram_address;
        word_t          o_ram_wr_data;
        ben_t           o_ram_ben;
        word_t          i_ram_rd_data;
        logic           i_ram_done;

        word_t          ram_mem [RAM_WORDS];    // RAM model contents.
        int             seed;
        int             rd_count;               // RAM reads completed.
        int             wr_count;               // RAM writes completed.
        int             busy;                   // RAM command in progress.
        int             wait_cnt;               // Cycles left before done.
        int             cycle_count = 0;
        addr_t          rd_log [$];             // Read addresses, in order.
        addr_t          last_wr_addr;
        ben_t           last_wr_ben;
        ctrl_state_t    hang_state;

        dcache_top #(.CACHE_LINES(CACHE_LINES)) dcache_top_inst (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_read_en      (i_read_en),
                .i_write_en     (i_write_en),
                .i_ben          (i_ben),
                .i_wr_data      (i_wr_data),
                .i_address      (i_address),
                .i_cache_en     (i_cache_en),
                .i_cache_inv    (i_cache_inv),
                .o_rd_data      (o_rd_data),
                .o_stall        (o_stall),
                .o_ram_rd_en    (o_ram_rd_en),
                .o_ram_wr_en    (o_ram_wr_en),
                .o_ram_address  (o_ram_address),
                .o_ram_wr_data  (o_ram_wr_data),
                .o_ram_ben      (o_ram_ben),
                .i_ram_rd_data  (i_ram_rd_data),
                .i_ram_done     (i_ram_done)
        );

        always #2 i_clk = ~i_clk;       // 4 ns period.

        // --------------------------------------------------
        // Helpers and compare tasks.
        // --------------------------------------------------
        function automatic int ram_index(input addr_t a);
                return int'(a[13:2]);   // Word address within model RAM.
        endfunction

        // Byte-wise merge of new data into an old word.
        function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                              input ben_t ben);
                word_t res;
                res = old_w;
                for (int b = 0; b < WORD_W/8; b++)
                        if (ben[b])
                                res[b*8 +: 8] = new_w[b*8 +: 8];
                return res;
        endfunction

        task automatic stop_with_failure(input string msg);
                $display("%s", msg);
                $display("Result: FAILED");
                $fatal(1, "run stopped at first error");
        endtask

        task automatic check_word(input string name, input word_t got, input word_t exp);
                if (got !== exp)
                        stop_with_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                                    $time, name, got, exp));
        endtask

        task automatic check_addr(input string name, input addr_t got, input addr_t exp);
                if (got !== exp)
                        stop_with_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                                    $time, name, got, exp));
        endtask

        task automatic check_ben(input string name, input ben_t got, input ben_t exp);
                if (got !== exp)
                        stop_with_failure($sformatf("mismatch at %0t: %s got %b expected %b",
                                                    $time, name, got, exp));
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                if (got !== exp)
                        stop_with_failure($sformatf("mismatch at %0t: %s got %b expected %b",
                                                    $time, name, got, exp));
        endtask

        task automatic check_count(input string name, input int got, input int exp);
                if (got != exp)
                        stop_with_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                                    $time, name, got, exp));
        endtask

        // --------------------------------------------------
        // RAM model. Samples mid-cycle, drives after the edge.
        // --------------------------------------------------
        always @(negedge i_clk)
        begin
                logic  done_nxt;
                word_t data_nxt;
                done_nxt = 1'b0;
                data_nxt = i_ram_rd_data;
                if (i_reset)
                        busy = 0;
                else if (i_ram_done && (o_ram_rd_en || o_ram_wr_en))
                begin
                        // Command ends at the coming edge.
                        if (o_ram_wr_en)
                        begin
                                ram_mem[ram_index(o_ram_address)] = merge_bytes(
                                        ram_mem[ram_index(o_ram_address)], o_ram_wr_data,
                                        o_ram_ben);
                                last_wr_addr = o_ram_address;
                                last_wr_ben  = o_ram_ben;
                                wr_count++;
                        end
                        else
                        begin
                                rd_log.push_back(o_ram_address);
                                rd_count++;
                        end
                        busy = 0;
                end
                else if (o_ram_rd_en || o_ram_wr_en)
                begin
                        if (busy == 0)
                        begin
                                busy     = 1;
                                wait_cnt = $random(seed) & 3;   // 0 to 3 cycles.
                        end
                        if (wait_cnt == 0)
                        begin
                                done_nxt = 1'b1;
                                data_nxt = ram_mem[ram_index(o_ram_address)];
                        end
                        else
                                wait_cnt--;
                end
                @(posedge i_clk);
                #1;
                i_ram_done    = done_nxt;
                i_ram_rd_data = data_nxt;
        end

        // Run limit.
        always @(posedge i_clk)
        begin
                cycle_count++;
                if (cycle_count >= MAX_CYCLES)
                begin
                        hang_state = dcache_top_inst.dcache_ctrl_inst.state_ff;
                        stop_with_failure($sformatf(
                                "timeout: tests did not finish in %0d cycles, controller in %s",
                                MAX_CYCLES, hang_state.name()));
                end
        end

        // --------------------------------------------------
        // Core-side access tasks. All start 1 ns after an edge.
        // --------------------------------------------------
        task automatic access_cache(input logic write, input addr_t addr, input ben_t ben,
                                    input word_t wdata, output word_t rdata, output int cycles);
                cycles     = 0;
                i_read_en  = !write;
                i_write_en = write;
                i_address  = addr;
                i_ben      = ben;
                i_wr_data  = wdata;
                do
                begin
                        @(negedge i_clk);
                        cycles++;
                end while (o_stall);
                rdata = o_rd_data;      // Valid only in the completing cycle.
                @(posedge i_clk);
                #1;
                i_read_en  = 1'b0;
                i_write_en = 1'b0;
        endtask

        task automatic read_check(input addr_t addr, input word_t exp, input int exp_reads,
                                  output int cycles);
                word_t got;
                int    rd_before;
                rd_before = rd_count;
                access_cache(1'b0, addr, 4'hf, '0, got, cycles);
                check_word("o_rd_data", got, exp);
                check_count("RAM reads", rd_count - rd_before, exp_reads);
        endtask

        task automatic write_check(input addr_t addr, input ben_t ben, input word_t data);
                word_t exp;
                word_t unused;
                int    cycles;
                int    wr_before;
                exp       = merge_bytes(ram_mem[ram_index(addr)], data, ben);
                wr_before = wr_count;
                access_cache(1'b1, addr, ben, data, unused, cycles);
                check_count("RAM writes", wr_count - wr_before, 1);
                check_word("RAM word", ram_mem[ram_index(addr)], exp);
        endtask

        // --------------------------------------------------
        // Directed tests.
        // --------------------------------------------------
        task automatic test_reset;
                @(negedge i_clk);
                check_bit("o_stall", o_stall, 1'b0);
                check_bit("o_ram_rd_en", o_ram_rd_en, 1'b0);
                check_bit("o_ram_wr_en", o_ram_wr_en, 1'b0);
                @(posedge i_clk);
                #1;
        endtask

        task automatic test_miss_hit(input addr_t base);
                int cycles;
                rd_log.delete();
                read_check(base + 4, ram_mem[ram_index(base + 4)], 4, cycles);
                for (int i = 0; i < WORDS_PER_LINE; i++)
                        check_addr("fill o_ram_address", rd_log[i], base + addr_t'(4 * i));
                read_check(base + 8, ram_mem[ram_index(base + 8)], 0, cycles);
                check_count("read hit cycles", cycles, 2);      // Stall low in cycle two.
        endtask

        task automatic test_write_through(input addr_t cached, input addr_t uncached);
                int cycles;
                write_check(cached, 4'b0101, 32'haabb_ccdd);
                read_check(cached, ram_mem[ram_index(cached)], 0, cycles);
                write_check(uncached, 4'b1100, 32'h1234_5678);
                read_check(uncached, ram_mem[ram_index(uncached)], 4, cycles); // No allocate.
        endtask

        task automatic test_conflict(input addr_t a, input addr_t b);
                int cycles;
                for (int r = 0; r < 2; r++)
                begin
                        read_check(a, ram_mem[ram_index(a)], 4, cycles);
                        read_check(b, ram_mem[ram_index(b)], 4, cycles);
                end
        endtask

        task automatic test_invalidate(input addr_t addr);
                int cycles;
                read_check(addr, ram_mem[ram_index(addr)], 0, cycles);  // Still cached.
                i_cache_inv = 1'b1;
                @(posedge i_clk);
                #1;
                i_cache_inv = 1'b0;
                read_check(addr, ram_mem[ram_index(addr)], 4, cycles);
        endtask

        task automatic test_bypass(input addr_t addr);
                int cycles;
                i_cache_en = 1'b0;
                @(posedge i_clk);
                #1;
                read_check(addr, ram_mem[ram_index(addr)], 1, cycles);
                check_addr("bypass read address", rd_log[rd_log.size() - 1], addr);
                write_check(addr, 4'b0010, 32'hcafe_f00d);
                check_addr("bypass write address", last_wr_addr, addr);
                check_ben("bypass write o_ram_ben", last_wr_ben, 4'b0010);
                read_check(addr, ram_mem[ram_index(addr)], 1, cycles);
                i_cache_en = 1'b1;
                @(posedge i_clk);
                #1;
        endtask

        // --------------------------------------------------
        // Main sequence.
        // --------------------------------------------------
        initial
        begin
                seed = 32'h1650;
                for (int i = 0; i < RAM_WORDS; i++)
                        ram_mem[i] = $random(seed);
                i_clk         = 1'b0;
                i_reset       = 1'b1;
                i_read_en     = 1'b0;
                i_write_en    = 1'b0;
                i_ben         = '0;
                i_wr_data     = '0;
                i_address     = '0;
                i_cache_en    = 1'b1;
                i_cache_inv   = 1'b0;
                i_ram_rd_data = '0;
                i_ram_done    = 1'b0;
                rd_count      = 0;
                wr_count      = 0;
                busy          = 0;
                wait_cnt      = 0;
                repeat (2) @(posedge i_clk);
                #1;
                i_reset = 1'b0;

                test_reset();
                test_miss_hit(32'h0000_0100);
                test_write_through(32'h0000_0108, 32'h0000_0800);
                test_conflict(32'h0000_0200, 32'h0000_0600);    // Both index 32.
                test_invalidate(32'h0000_0104);
                test_bypass(32'h0000_0304);

                $display("Result: PASSED");
                $finish;
        end

endmodule

/* filelist.f */
common/dcache_pkg.sv
dcache/fill_counter.sv
dcache/tag_store.sv
dcache/line_store.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
tests/dcache_tb.sv

/* Makefile */
# Verilator build and run of the data cache testbench.

VERILATOR  ?= verilator
TOP        := dcache_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_TEXT  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass message shows up in the output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
